/* rtl/fft16_cfg.svh */
`ifndef FFT16_CFG_SVH
`define FFT16_CFG_SVH

// width of the input samples, real and imaginary parts
`define FFT16_SAMPLE_W 16
// width after quarter scaling or twiddle rotation
`define FFT16_SCALED_W 15
// width of the butterfly outputs
`define FFT16_OUT_W 16

// twiddle parts are signed Q1.9, sign plus one integer bit, so 512 is exactly 1.0
`define FFT16_TW_W 11
`define FFT16_TW_FRAC 9

// quarter scaling applied to every group
`define FFT16_SCALE_SH 2

// samples per input group and per output group
`define FFT16_GRP_N 8
`define FFT16_HALF_N 4

// one address per even twiddle W0 .. W14
`define FFT16_TW_ADDR_W 3

`endif

/* rtl/fft16_pkg.sv */
`include "fft16_cfg.svh"

package fft16_pkg;

    // complex input sample, also used for the output groups
    typedef struct packed {
        logic signed [`FFT16_SAMPLE_W-1:0] re;
        logic signed [`FFT16_SAMPLE_W-1:0] im;
    } sample_t;

    // complex value after scaling or rotation
    typedef struct packed {
        logic signed [`FFT16_SCALED_W-1:0] re;
        logic signed [`FFT16_SCALED_W-1:0] im;
    } scaled_t;

    // complex twiddle factor
    typedef struct packed {
        logic signed [`FFT16_TW_W-1:0] re;
        logic signed [`FFT16_TW_W-1:0] im;
    } tw_t;

    typedef sample_t [`FFT16_GRP_N-1:0] grp_in_t;
    typedef scaled_t [`FFT16_GRP_N-1:0] grp_scaled_t;
    typedef sample_t [`FFT16_HALF_N-1:0] grp_out_t;

    // entry n holds W(2n)
    typedef tw_t [`FFT16_GRP_N-1:0] tw_bank_t;

endpackage

/* rtl/scaled_if.sv */
`timescale 1ns/10ps

// carries the four scaled or rotated groups between the two pipeline stages
interface scaled_if import fft16_pkg::*; ();

    grp_scaled_t grp_a;
    grp_scaled_t grp_b;
    grp_scaled_t grp_c;
    grp_scaled_t grp_d;

    modport src (
        output grp_a,
        output grp_b,
        output grp_c,
        output grp_d
    );

    modport dst (
        input grp_a,
        input grp_b,
        input grp_c,
        input grp_d
    );

endinterface

/* rtl/twiddle_regs.sv */
`timescale 1ns/10ps
`include "fft16_cfg.svh"

module twiddle_regs import fft16_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        tw_we_i,
    input  logic [`FFT16_TW_ADDR_W-1:0] tw_addr_i,
    input  tw_t                         tw_data_i,
    output tw_bank_t                    tw_bank_o
);

    // 1.0 + 0j, so an unconfigured stage passes samples through unrotated
    localparam tw_t TW_UNIT = '{
        re: `FFT16_TW_W'(1 << `FFT16_TW_FRAC),
        im: '0
    };

    // the bank is read straight from the flops, so a write is seen one edge later
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int n = 0; n < `FFT16_GRP_N; n++) begin
                tw_bank_o[n] <= TW_UNIT;
            end
        end else if (tw_we_i) begin
            tw_bank_o[tw_addr_i] <= tw_data_i;
        end
    end

endmodule

/* rtl/rotate_scale.sv */
`timescale 1ns/10ps
`include "fft16_cfg.svh"

module rotate_scale import fft16_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  grp_in_t  grp_a_i,
    input  grp_in_t  grp_b_i,
    input  grp_in_t  grp_c_i,
    input  grp_in_t  grp_d_i,
    input  tw_bank_t tw_bank_i,
    scaled_if.src    scl
);

    // full product width: sample times twiddle, plus one bit for the sum of two products
    localparam int PROD_W = `FFT16_SAMPLE_W + `FFT16_TW_W + 1;
    // twiddle fraction removal and quarter scaling in one shift
    localparam int ROT_SH = `FFT16_TW_FRAC + `FFT16_SCALE_SH;

    // arithmetic quarter, the result always fits in the scaled width
    function automatic scaled_t quarter(sample_t x);
        logic signed [`FFT16_SAMPLE_W-1:0] sh_re;
        logic signed [`FFT16_SAMPLE_W-1:0] sh_im;
        scaled_t r;
        sh_re = x.re >>> `FFT16_SCALE_SH;
        sh_im = x.im >>> `FFT16_SCALE_SH;
        r.re  = sh_re[`FFT16_SCALED_W-1:0];
        r.im  = sh_im[`FFT16_SCALED_W-1:0];
        return r;
    endfunction

    // complex multiply, then keep the 15 bits above the shift so large values wrap
    function automatic scaled_t rotate(sample_t x, tw_t w);
        logic signed [PROD_W-1:0] acc_re;
        logic signed [PROD_W-1:0] acc_im;
        scaled_t r;
        acc_re = $signed(x.re) * $signed(w.re) - $signed(x.im) * $signed(w.im);
        acc_im = $signed(x.re) * $signed(w.im) + $signed(x.im) * $signed(w.re);
        r.re   = acc_re[ROT_SH +: `FFT16_SCALED_W];
        r.im   = acc_im[ROT_SH +: `FFT16_SCALED_W];
        return r;
    endfunction

    function automatic grp_scaled_t quarter_grp(grp_in_t g);
        grp_scaled_t r;
        for (int k = 0; k < `FFT16_GRP_N; k++) begin
            r[k] = quarter(g[k]);
        end
        return r;
    endfunction

    // sample k of the group meets twiddle entry k, that is W(2k)
    function automatic grp_scaled_t rotate_grp(grp_in_t g, tw_bank_t tw);
        grp_scaled_t r;
        for (int k = 0; k < `FFT16_GRP_N; k++) begin
            r[k] = rotate(g[k], tw[k]);
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            scl.grp_a <= '0;
            scl.grp_b <= '0;
            scl.grp_c <= '0;
            scl.grp_d <= '0;
        end else begin
            scl.grp_a <= quarter_grp(grp_a_i);
            scl.grp_b <= rotate_grp(grp_b_i, tw_bank_i);
            scl.grp_c <= quarter_grp(grp_c_i);
            scl.grp_d <= rotate_grp(grp_d_i, tw_bank_i);
        end
    end

endmodule

/* rtl/butterfly_stage.sv */
`timescale 1ns/10ps
`include "fft16_cfg.svh"

module butterfly_stage import fft16_pkg::*; (
    input  logic clk,
    input  logic rst_n_i,
    scaled_if.dst scl,
    output grp_out_t out_a_o,
    output grp_out_t out_b_o,
    output grp_out_t out_c_o,
    output grp_out_t out_d_o,
    output grp_out_t out_e_o,
    output grp_out_t out_f_o,
    output grp_out_t out_g_o,
    output grp_out_t out_h_o
);

    localparam int EXT_W = `FFT16_OUT_W - `FFT16_SCALED_W;

    // one guard bit makes the sum and the difference of two scaled values exact
    function automatic logic [`FFT16_OUT_W-1:0] sext(logic [`FFT16_SCALED_W-1:0] v);
        return {{EXT_W{v[`FFT16_SCALED_W-1]}}, v};
    endfunction

    // sums when diff is low, differences of x[k] and x[k+4] when it is high
    function automatic grp_out_t bfly(grp_scaled_t g, logic diff);
        grp_out_t r;
        scaled_t  lo;
        scaled_t  hi;
        for (int k = 0; k < `FFT16_HALF_N; k++) begin
            lo = g[k];
            hi = g[k + `FFT16_HALF_N];
            if (diff) begin
                r[k].re = sext(lo.re) - sext(hi.re);
                r[k].im = sext(lo.im) - sext(hi.im);
            end else begin
                r[k].re = sext(lo.re) + sext(hi.re);
                r[k].im = sext(lo.im) + sext(hi.im);
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_a_o <= '0;
            out_b_o <= '0;
            out_c_o <= '0;
            out_d_o <= '0;
            out_e_o <= '0;
            out_f_o <= '0;
            out_g_o <= '0;
            out_h_o <= '0;
        end else begin
            // each group feeds a pair of outputs, sum first and difference second
            out_a_o <= bfly(scl.grp_a, 1'b0);
            out_b_o <= bfly(scl.grp_a, 1'b1);
            out_c_o <= bfly(scl.grp_b, 1'b0);
            out_d_o <= bfly(scl.grp_b, 1'b1);
            out_e_o <= bfly(scl.grp_c, 1'b0);
            out_f_o <= bfly(scl.grp_c, 1'b1);
            out_g_o <= bfly(scl.grp_d, 1'b0);
            out_h_o <= bfly(scl.grp_d, 1'b1);
        end
    end

endmodule

/* rtl/fft16_stage.sv */
`timescale 1ns/10ps
`include "fft16_cfg.svh"

module fft16_stage import fft16_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        tw_we_i,
    input  logic [`FFT16_TW_ADDR_W-1:0] tw_addr_i,
    input  tw_t                         tw_data_i,
    input  grp_in_t                     grp_a_i,
    input  grp_in_t                     grp_b_i,
    input  grp_in_t                     grp_c_i,
    input  grp_in_t                     grp_d_i,
    output grp_out_t                    out_a_o,
    output grp_out_t                    out_b_o,
    output grp_out_t                    out_c_o,
    output grp_out_t                    out_d_o,
    output grp_out_t                    out_e_o,
    output grp_out_t                    out_f_o,
    output grp_out_t                    out_g_o,
    output grp_out_t                    out_h_o
);

    tw_bank_t tw_bank;

    // stage 1 to stage 2 register boundary
    scaled_if scl_if ();

    twiddle_regs twiddle_regs_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .tw_we_i   (tw_we_i),
        .tw_addr_i (tw_addr_i),
        .tw_data_i (tw_data_i),
        .tw_bank_o (tw_bank)
    );

    rotate_scale rotate_scale_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .grp_a_i   (grp_a_i),
        .grp_b_i   (grp_b_i),
        .grp_c_i   (grp_c_i),
        .grp_d_i   (grp_d_i),
        .tw_bank_i (tw_bank),
        .scl       (scl_if.src)
    );

    butterfly_stage butterfly_stage_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .scl     (scl_if.dst),
        .out_a_o (out_a_o),
        .out_b_o (out_b_o),
        .out_c_o (out_c_o),
        .out_d_o (out_d_o),
        .out_e_o (out_e_o),
        .out_f_o (out_f_o),
        .out_g_o (out_g_o),
        .out_h_o (out_h_o)
    );

endmodule

/* test/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // reset is synchronous, so hold it low over RST_CYCLES rising edges and let go between edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

/* test/tb_fft16_stage.sv */
`timescale 1ns/10ps
`include "fft16_cfg.svh"

module tb_fft16_stage import fft16_pkg::*; ();

    // all eight output groups of one vector with out_a at index 0 and out_h at index 7
    typedef grp_out_t [7:0] out_set_t;

    localparam int ROT_SH = `FFT16_TW_FRAC + `FFT16_SCALE_SH;

    logic clk;
    logic rst_n;
    logic tw_we;
    logic [`FFT16_TW_ADDR_W-1:0] tw_addr;
    tw_t tw_data;
    grp_in_t grp_a;
    grp_in_t grp_b;
    grp_in_t grp_c;
    grp_in_t grp_d;
    grp_out_t out_a;
    grp_out_t out_b;
    grp_out_t out_c;
    grp_out_t out_d;
    grp_out_t out_e;
    grp_out_t out_f;
    grp_out_t out_g;
    grp_out_t out_h;

    // the front entry holds the expected outputs of the older vector in flight
    out_set_t exp_q[$];
    int id_q[$];
    // real and imaginary parts of the model twiddle entries
    int bank_re [8];
    int bank_im [8];
    int push_cnt = 0;
    int last_checked = -1;
    int chk_cnt = 0;
    int err_cnt = 0;
    int test_cnt = 0;
    int test_chk0 = 0;
    int test_err0 = 0;
    bit check_en = 1'b0;
    bit timeout_hit = 1'b0;

    clk_gen clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fft16_stage fft16_stage_i (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .tw_we_i   (tw_we),
        .tw_addr_i (tw_addr),
        .tw_data_i (tw_data),
        .grp_a_i   (grp_a),
        .grp_b_i   (grp_b),
        .grp_c_i   (grp_c),
        .grp_d_i   (grp_d),
        .out_a_o   (out_a),
        .out_b_o   (out_b),
        .out_c_o   (out_c),
        .out_d_o   (out_d),
        .out_e_o   (out_e),
        .out_f_o   (out_f),
        .out_g_o   (out_g),
        .out_h_o   (out_h)
    );

    // keeps the low 15 bits of a value as a signed number
    function automatic int wrap15(int v);
        logic signed [`FFT16_SCALED_W-1:0] low;
        low = v[`FFT16_SCALED_W-1:0];
        return low;
    endfunction

    function automatic out_set_t model_vector(grp_in_t a, grp_in_t b, grp_in_t c, grp_in_t d);
        grp_in_t grps [4];
        int sr [8];
        int si [8];
        int xr;
        int xi;
        int wr;
        int wi;
        out_set_t r;
        grps[0] = a;
        grps[1] = b;
        grps[2] = c;
        grps[3] = d;
        for (int gi = 0; gi < 4; gi++) begin
            for (int k = 0; k < 8; k++) begin
                xr = grps[gi][k].re;
                xi = grps[gi][k].im;
                // A and C are quartered, B and D are rotated by W(2k)
                if (gi % 2 == 0) begin
                    sr[k] = xr >>> `FFT16_SCALE_SH;
                    si[k] = xi >>> `FFT16_SCALE_SH;
                end else begin
                    wr = bank_re[k];
                    wi = bank_im[k];
                    sr[k] = wrap15((xr * wr - xi * wi) >>> ROT_SH);
                    si[k] = wrap15((xr * wi + xi * wr) >>> ROT_SH);
                end
            end
            for (int k = 0; k < 4; k++) begin
                r[2 * gi][k].re     = sr[k] + sr[k + 4];
                r[2 * gi][k].im     = si[k] + si[k + 4];
                r[2 * gi + 1][k].re = sr[k] - sr[k + 4];
                r[2 * gi + 1][k].im = si[k] - si[k + 4];
            end
        end
        return r;
    endfunction

    // a vector sampled at an edge uses the model bank as it was before that edge's write
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_q.push_back('0);
            for (int n = 0; n < 8; n++) begin
                bank_re[n] = 1 << `FFT16_TW_FRAC;
                bank_im[n] = 0;
            end
        end else begin
            exp_q.push_back(model_vector(grp_a, grp_b, grp_c, grp_d));
            if (tw_we) begin
                bank_re[tw_addr] = tw_data.re;
                bank_im[tw_addr] = tw_data.im;
            end
        end
        id_q.push_back(push_cnt);
        push_cnt++;
        if (exp_q.size() > 2) begin
            exp_q.delete(0);
            id_q.delete(0);
        end
    end

    task automatic check_group(input string name, input grp_out_t got, input grp_out_t want);
        assert (got === want) else begin
            $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, want, got);
            err_cnt++;
        end
    endtask

    // outputs settle after the rising edge, so compare them half a cycle later
    always @(negedge clk) begin
        if (check_en && exp_q.size() == 2) begin
            check_group("out_a_o", out_a, exp_q[0][0]);
            check_group("out_b_o", out_b, exp_q[0][1]);
            check_group("out_c_o", out_c, exp_q[0][2]);
            check_group("out_d_o", out_d, exp_q[0][3]);
            check_group("out_e_o", out_e, exp_q[0][4]);
            check_group("out_f_o", out_f, exp_q[0][5]);
            check_group("out_g_o", out_g, exp_q[0][6]);
            check_group("out_h_o", out_h, exp_q[0][7]);
            last_checked = id_q[0];
            chk_cnt++;
        end
    end

    function automatic tw_t make_tw(int re, int im);
        tw_t w;
        w.re = re;
        w.im = im;
        return w;
    endfunction

    function automatic tw_t random_twiddle();
        return make_tw($urandom_range(1023) - 512, $urandom_range(1023) - 512);
    endfunction

    function automatic grp_in_t random_group();
        grp_in_t g;
        for (int k = 0; k < 8; k++) begin
            g[k] = $urandom;
        end
        return g;
    endfunction

    // every part is either the most negative or the most positive sample
    function automatic grp_in_t extreme_group();
        grp_in_t g;
        for (int k = 0; k < 8; k++) begin
            g[k].re = $urandom_range(1) ? 16'sh8000 : 16'sh7fff;
            g[k].im = $urandom_range(1) ? 16'sh8000 : 16'sh7fff;
        end
        return g;
    endfunction

    task automatic drive_cycle(input logic we, input logic [`FFT16_TW_ADDR_W-1:0] addr,
                               input tw_t data, input grp_in_t a, input grp_in_t b,
                               input grp_in_t c, input grp_in_t d);
        @(negedge clk);
        tw_we   = we;
        tw_addr = addr;
        tw_data = data;
        grp_a   = a;
        grp_b   = b;
        grp_c   = c;
        grp_d   = d;
    endtask

    task automatic drive_vector(input grp_in_t a, input grp_in_t b, input grp_in_t c,
                                input grp_in_t d);
        drive_cycle(1'b0, '0, '0, a, b, c, d);
    endtask

    task automatic random_vector();
        drive_vector(random_group(), random_group(), random_group(), random_group());
    endtask

    task automatic write_twiddle(input int addr, input tw_t data);
        drive_cycle(1'b1, addr, data, grp_a, grp_b, grp_c, grp_d);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was still active after 20 cycles");
            timeout_hit = 1'b1;
        end
    endtask

    // waits until the last driven vector has been compared at the outputs
    task automatic drain(input string what);
        int target;
        int n;
        @(negedge clk);
        tw_we  = 1'b0;
        target = push_cnt - 1;
        n = 0;
        @(posedge clk);
        while (last_checked < target && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (last_checked < target) begin
            $display("timeout: %s did not reach the outputs within 10 cycles", what);
            timeout_hit = 1'b1;
        end
    endtask

    task automatic start_test();
        test_cnt++;
        test_chk0 = chk_cnt;
        test_err0 = err_cnt;
    endtask

    task automatic end_test(input string name);
        $display("test %0d %s: %0d checks, %0d failures", test_cnt, name,
                 chk_cnt - test_chk0, err_cnt - test_err0);
    endtask

    initial begin
        int seed_dummy;
        seed_dummy = $urandom(78);
        tw_we   = 1'b0;
        tw_addr = '0;
        tw_data = '0;
        grp_a   = '0;
        grp_b   = '0;
        grp_c   = '0;
        grp_d   = '0;
        wait_reset();
        check_en = 1'b1;

        start_test();
        for (int i = 0; i < 4; i++) begin
            drive_vector('0, '0, '0, '0);
        end
        drain("idle vectors");
        end_test("zero outputs after reset");

        start_test();
        for (int i = 0; i < 20; i++) begin
            random_vector();
        end
        drain("unit twiddle vectors");
        end_test("quarter scaling with reset twiddles");

        start_test();
        for (int n = 0; n < 8; n++) begin
            write_twiddle(n, random_twiddle());
        end
        for (int i = 0; i < 20; i++) begin
            random_vector();
        end
        drain("rotated vectors");
        end_test("rotation by random twiddles");

        // entry 3 changes in the same cycle as a vector, which must still see the old value
        start_test();
        write_twiddle(3, make_tw(0, -512));
        random_vector();
        drive_cycle(1'b1, 3, make_tw(362, -362), random_group(), random_group(),
                    random_group(), random_group());
        random_vector();
        drain("write collision vectors");
        end_test("twiddle write and vector in one cycle");

        start_test();
        for (int i = 0; i < 50; i++) begin
            random_vector();
        end
        drain("back to back vectors");
        end_test("vector on every cycle");

        start_test();
        for (int n = 0; n < 8; n++) begin
            write_twiddle(n, make_tw(n[0] ? -512 : 511, n[1] ? -512 : 511));
        end
        for (int i = 0; i < 16; i++) begin
            drive_vector(extreme_group(), extreme_group(), extreme_group(), extreme_group());
        end
        drain("extreme vectors");
        end_test("extreme samples and twiddles");

        $display("%0d tests, %0d checks, %0d failures, timeout %0d",
                 test_cnt, chk_cnt, err_cnt, timeout_hit);
        if (err_cnt == 0 && !timeout_hit) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* fft16_stage.f */
+incdir+rtl
rtl/fft16_pkg.sv
rtl/scaled_if.sv
rtl/twiddle_regs.sv
rtl/rotate_scale.sv
rtl/butterfly_stage.sv
rtl/fft16_stage.sv
test/clk_gen.sv
test/tb_fft16_stage.sv

/* Bender.yml */
package:
  name: fft16_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fft16_pkg.sv
      - rtl/scaled_if.sv
      - rtl/twiddle_regs.sv
      - rtl/rotate_scale.sv
      - rtl/butterfly_stage.sv
      - rtl/fft16_stage.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/clk_gen.sv
      - test/tb_fft16_stage.sv
